//--- logic/memStage_config.svh
/*
 * Memory stage sizing: bus watchdog limit and the
 * general exception vector used on a flush.
 */

`ifndef MEMSTAGE_CONFIG_SVH
`define MEMSTAGE_CONFIG_SVH

// response-wait cycles before the access is given up as DBE
`define BUS_TIMEOUT 16

// boot-time exception base, BEV=1
`define EXC_BASE 32'hBFC0_0200

`define EXC_OFFSET 32'h0000_0180 // general exception entry

`endif

//--- logic/memStagePkg.sv
/*
 * Memory stage types: access kinds, MIPS cause codes,
 * the EXE/MEM and MEM/WB bundles and the AXI4-Lite request
 * and response groups.
 */

`default_nettype none

package memStagePkg;

    typedef enum logic [2:0] {
        kindNone, kindLb, kindLh, kindLw, kindSb, kindSh, kindSw
    } accessKind;

    // values as in the CP0 Cause.ExcCode field
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5,
        excDbe  = 5'd7,
        excSys  = 5'd8,
        excOv   = 5'd12
    } excCode;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;    // address for memory ops
        logic [31:0] storeData;
        accessKind   kind;
        logic        loadSigned;
        logic [4:0]  dst;
        logic        regWrite;
        excCode      exc;       // raised earlier in the pipe
    } exeMemBundle;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dst;
        logic        regWrite;
    } memWbBundle;

    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axiReq;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiRsp;

endpackage

`default_nettype wire

//--- logic/pipeReg.sv
/*
 * Pipeline stage register for any payload type.
 * Holds on hold, clears on flush.
 */

`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0; // flush wins over hold
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- logic/dataAlign.sv
/*
 * Data alignment for the memory stage: misalignment check,
 * store lane placement with byte strobes, and load lane
 * extraction with sign or zero extension.
 */

`timescale 1ns/1ps
`default_nettype none

module dataAlign import memStagePkg::*; (
    input  exeMemBundle stage,
    input  logic [31:0] rdata,
    output logic        misaligned,
    output logic [3:0]  wstrb,
    output logic [31:0] wdata,
    output logic [31:0] loadResult
);

    logic [1:0]  offs;
    logic        isHalf;
    logic        isWord;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    assign offs   = stage.aluOut[1:0];
    assign isHalf = (stage.kind == kindLh) || (stage.kind == kindSh);
    assign isWord = (stage.kind == kindLw) || (stage.kind == kindSw);

    assign misaligned = stage.valid && ((isHalf && offs[0]) || (isWord && (offs != 2'b00)));

    // store side, data replicated so the strobe picks the lane
    always_comb begin
        case (stage.kind)
            kindSb: begin
                wdata = {4{stage.storeData[7:0]}};
                wstrb = 4'b0001 << offs;
            end
            kindSh: begin
                wdata = {2{stage.storeData[15:0]}};
                wstrb = offs[1] ? 4'b1100 : 4'b0011;
            end
            kindSw: begin
                wdata = stage.storeData;
                wstrb = 4'b1111;
            end
            default: begin
                wdata = stage.storeData;
                wstrb = 4'b0000; // no write
            end
        endcase
    end

    assign byteLane = rdata[{offs, 3'b000} +: 8];
    assign halfLane = offs[1] ? rdata[31:16] : rdata[15:0];

    // non-loads pass the ALU result through to writeback
    always_comb begin
        case (stage.kind)
            kindLb:  loadResult = {{24{stage.loadSigned & byteLane[7]}}, byteLane};
            kindLh:  loadResult = {{16{stage.loadSigned & halfLane[15]}}, halfLane};
            kindLw:  loadResult = rdata;
            default: loadResult = stage.aluOut;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/excPriority.sv
/*
 * Exception merge for the memory stage. Incoming cause first,
 * then address error, then bus error; raises the flush.
 */

`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module excPriority import memStagePkg::*; (
    input  exeMemBundle stage,
    input  logic        misaligned,
    input  logic        busError,
    output logic        excFlush,
    output excCode      excCodeOut,
    output logic [31:0] excPc,
    output logic [31:0] excVector
);

    logic isStore;

    assign isStore = (stage.kind == kindSb) || (stage.kind == kindSh) || (stage.kind == kindSw);

    always_comb begin
        excCodeOut = excNone;
        if (stage.valid) begin
            if (stage.exc != excNone) begin
                excCodeOut = stage.exc; // from EXE or earlier
            end else if (misaligned) begin
                excCodeOut = isStore ? excAdES : excAdEL;
            end else if (busError) begin
                excCodeOut = excDbe;
            end
        end
    end

    assign excFlush  = (excCodeOut != excNone);
    assign excPc     = stage.pc;
    assign excVector = `EXC_BASE + `EXC_OFFSET; // no EBase, fixed entry

endmodule

`default_nettype wire

//--- logic/accessTimer.sv
/*
 * Bus watchdog. Counts response-wait cycles and flags
 * expiry at the configured limit.
 */

`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module accessTimer (
    input  logic clk,
    input  logic arstN,
    input  logic run,
    output logic expired
);

    localparam int cntW = $clog2(`BUS_TIMEOUT + 1);

    logic [cntW-1:0] count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1; // saturates at the limit
        end
    end

    assign expired = (count == cntW'(`BUS_TIMEOUT));

endmodule

`default_nettype wire

//--- logic/busMaster.sv
/*
 * Uncached AXI4-Lite master, one access at a time.
 * Separate AW/W tracking, response latch, timeout drain
 * and the stall back to EXE.
 */

`timescale 1ns/1ps
`default_nettype none

module busMaster import memStagePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  exeMemBundle stage,
    input  logic        start,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        expired,
    output axiReq       axiOut,
    input  axiRsp       axiIn,
    output logic        waiting,
    output logic        done,
    output logic        busError,
    output logic [31:0] rdata,
    output logic        stall
);

    typedef enum logic [2:0] {stIdle, stAddr, stWrite, stResp, stDrain} busState;

    busState state;
    logic    isWrite;   // direction of the access in flight or in drain
    logic    awDone;
    logic    wDone;
    logic    isStore;
    logic    busy;
    logic    awHs;
    logic    wHs;
    logic    arHs;
    logic    rspHs;
    logic    rspErr;

    assign isStore = (stage.kind == kindSb) || (stage.kind == kindSh) || (stage.kind == kindSw);
    assign busy    = (state == stAddr) || (state == stWrite) || (state == stResp);
    assign stall   = busy || (start && !done); // done cycle lets the op leave
    assign waiting = (state == stResp);

    always_comb begin
        axiOut         = '0;
        axiOut.awvalid = (state == stWrite) && !awDone;
        axiOut.awaddr  = stage.aluOut;
        axiOut.wvalid  = (state == stWrite) && !wDone;
        axiOut.wdata   = wdata;
        axiOut.wstrb   = wstrb;
        axiOut.arvalid = (state == stAddr);
        axiOut.araddr  = stage.aluOut;
        axiOut.bready  = isWrite && ((state == stResp) || (state == stDrain));
        axiOut.rready  = !isWrite && ((state == stResp) || (state == stDrain));
    end

    assign awHs   = axiOut.awvalid && axiIn.awready;
    assign wHs    = axiOut.wvalid && axiIn.wready;
    assign arHs   = axiOut.arvalid && axiIn.arready;
    assign rspHs  = isWrite ? (axiIn.bvalid && axiOut.bready) : (axiIn.rvalid && axiOut.rready);
    assign rspErr = isWrite ? (axiIn.bresp != 2'b00) : (axiIn.rresp != 2'b00);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= stIdle;
            isWrite  <= 1'b0;
            awDone   <= 1'b0;
            wDone    <= 1'b0;
            done     <= 1'b0;
            busError <= 1'b0;
        end else begin
            done     <= 1'b0;
            busError <= 1'b0;
            case (state)
                stIdle: begin
                    if (start && !done) begin
                        isWrite <= isStore;
                        awDone  <= 1'b0;
                        wDone   <= 1'b0;
                        state   <= isStore ? stWrite : stAddr;
                    end
                end
                stAddr: begin
                    if (arHs) state <= stResp;
                end
                stWrite: begin
                    if (awHs) awDone <= 1'b1;
                    if (wHs) wDone <= 1'b1;
                    if ((awDone || awHs) && (wDone || wHs)) state <= stResp;
                end
                stResp: begin
                    if (rspHs) begin
                        done     <= 1'b1;
                        busError <= rspErr; // SLVERR/DECERR -> DBE
                        state    <= stIdle;
                    end else if (expired) begin
                        done     <= 1'b1;
                        busError <= 1'b1;
                        state    <= stDrain; // late response still owed
                    end
                end
                stDrain: begin
                    if (rspHs) state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == stResp) && rspHs && !isWrite) rdata <= axiIn.rdata;
    end

endmodule

`default_nettype wire

//--- logic/memStage.sv
/*
 * MEM stage of the five-stage pipeline: stage registers,
 * data alignment, exception merge and the AXI4-Lite master.
 */

`timescale 1ns/1ps
`default_nettype none

module memStage import memStagePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  exeMemBundle exeIn,
    output logic        memStall,
    output memWbBundle  wbOut,
    output logic        excFlush,
    output excCode      excCodeOut,
    output logic [31:0] excPc,
    output logic [31:0] excVector,
    output axiReq       axiOut,
    input  axiRsp       axiIn
);

    exeMemBundle stage;
    memWbBundle  wbNext;
    logic        misaligned;
    logic        startAccess;
    logic        waiting;
    logic        expired;
    logic        busError;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] loadResult;

    pipeReg #(.payloadT(exeMemBundle)) memReg (
        .clk   (clk),
        .arstN (arstN),
        .hold  (memStall),
        .flush (excFlush),
        .d     (exeIn),
        .q     (stage)
    );

    dataAlign i_dataAlign (
        .stage      (stage),
        .rdata      (rdata),
        .misaligned (misaligned),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .loadResult (loadResult)
    );

    excPriority i_excPriority (
        .stage      (stage),
        .misaligned (misaligned),
        .busError   (busError),
        .excFlush   (excFlush),
        .excCodeOut (excCodeOut),
        .excPc      (excPc),
        .excVector  (excVector)
    );

    // valid, aligned memory op with nothing raised upstream
    assign startAccess = stage.valid && (stage.kind != kindNone) && !misaligned &&
                         (stage.exc == excNone);

    accessTimer i_accessTimer (
        .clk     (clk),
        .arstN   (arstN),
        .run     (waiting),
        .expired (expired)
    );

    busMaster i_busMaster (
        .clk      (clk),
        .arstN    (arstN),
        .stage    (stage),
        .start    (startAccess),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .expired  (expired),
        .axiOut   (axiOut),
        .axiIn    (axiIn),
        .waiting  (waiting),
        .done     (),          // completion shows as stall dropping
        .busError (busError),
        .rdata    (rdata),
        .stall    (memStall)
    );

    assign wbNext.valid    = stage.valid;
    assign wbNext.pc       = stage.pc;
    assign wbNext.result   = loadResult;
    assign wbNext.dst      = stage.dst;
    assign wbNext.regWrite = stage.regWrite & ~excFlush; // no write for excepting ops

    // bubble into WB while the access is still pending
    pipeReg #(.payloadT(memWbBundle)) wbReg (
        .clk   (clk),
        .arstN (arstN),
        .hold  (1'b0),
        .flush (memStall),
        .d     (wbNext),
        .q     (wbOut)
    );

endmodule

`default_nettype wire

//--- dv/memStageTb.sv
/*
 * Testbench for the memory stage: AXI4-Lite slave model with random
 * ready delays, error and withheld-response regions, and a reference
 * model that predicts writeback results and exception codes.
 */

`timescale 1ns/1ps
`default_nettype none

`include "memStage_config.svh"

module memStageTb import memStagePkg::*; ();

    logic        clk;
    logic        arstN;
    exeMemBundle exeIn;
    logic        memStall;
    memWbBundle  wbOut;
    logic        excFlush;
    excCode      excCodeOut;
    logic [31:0] excPc;
    logic [31:0] excVector;
    axiReq       axiOut;
    axiRsp       axiIn;

    logic [31:0] mem [64];     // slave storage by word index addr[7:2]
    memWbBundle  expWb[$];
    bit          expKnown[$];  // result checked only for clean ops
    excCode      expCode[$];
    logic [31:0] expPc[$];
    int          wbTimes[$];
    int          cycle;
    logic [31:0] pcCount;
    axiReq       prevReq;
    axiRsp       prevRsp;
    bit          flushQ;       // flush seen in the previous cycle
    bit          rspOwed;      // address accepted, response not yet taken

    // slave side handshake record, taken at the rising edge
    bit          awHsQ;
    bit          wHsQ;
    bit          arHsQ;
    bit          bHsQ;
    bit          rHsQ;
    bit          awGot;
    bit          wGot;
    bit          arGot;
    bit          bPend;
    int          awDly;
    int          wDly;
    int          arDly;
    int          bDly;
    int          rDly;
    logic [31:0] awAddrQ;
    logic [31:0] arAddrQ;
    logic [31:0] wDataQ;
    logic [3:0]  wStrbQ;

    memStage i_dut (
        .clk        (clk),
        .arstN      (arstN),
        .exeIn      (exeIn),
        .memStall   (memStall),
        .wbOut      (wbOut),
        .excFlush   (excFlush),
        .excCodeOut (excCodeOut),
        .excPc      (excPc),
        .excVector  (excVector),
        .axiOut     (axiOut),
        .axiIn      (axiIn)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped");
    endtask

    // expected writeback and cause from the MIPS lane and priority rules
    function automatic void refModel(input exeMemBundle e, input logic [31:0] m [64],
                                     output memWbBundle w, output excCode x,
                                     output bit known);
        logic [1:0]  o;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        bit          isLd;
        bit          isSt;
        o    = e.aluOut[1:0];
        word = m[e.aluOut[7:2]];
        b    = word[o*8 +: 8];
        h    = o[1] ? word[31:16] : word[15:0];
        isLd = (e.kind == kindLb) || (e.kind == kindLh) || (e.kind == kindLw);
        isSt = (e.kind == kindSb) || (e.kind == kindSh) || (e.kind == kindSw);
        x = excNone;
        if (e.exc != excNone) x = e.exc;
        else if ((((e.kind == kindLh) || (e.kind == kindSh)) && o[0]) ||
                 (((e.kind == kindLw) || (e.kind == kindSw)) && (o != 2'b00)))
            x = isSt ? excAdES : excAdEL;
        else if ((isLd || isSt) && (e.aluOut[12] || e.aluOut[13])) x = excDbe;
        w.valid    = 1'b1;
        w.pc       = e.pc;
        w.dst      = e.dst;
        w.regWrite = e.regWrite && (x == excNone);
        case (e.kind)
            kindLb:  w.result = e.loadSigned ? {{24{b[7]}}, b} : {24'h0, b};
            kindLh:  w.result = e.loadSigned ? {{16{h[15]}}, h} : {16'h0, h};
            kindLw:  w.result = word;
            default: w.result = e.aluOut;
        endcase
        known = (x == excNone);
    endfunction

    function automatic exeMemBundle mkOp(input accessKind k, input logic [31:0] a,
                                         input logic [31:0] d, input bit sgn,
                                         input excCode x);
        exeMemBundle e;
        e.valid      = 1'b1;
        e.pc         = pcCount;
        e.aluOut     = a;
        e.storeData  = d;
        e.kind       = k;
        e.loadSigned = sgn;
        e.dst        = 5'(1 + ($urandom % 31));
        e.regWrite   = (k == kindNone) || (k == kindLb) || (k == kindLh) || (k == kindLw);
        e.exc        = x;
        pcCount      = pcCount + 32'd4;
        return e;
    endfunction

    task automatic checkWb(input memWbBundle got, input memWbBundle exp, input bit known);
        if (got.pc !== exp.pc || got.dst !== exp.dst || got.regWrite !== exp.regWrite)
            fail($sformatf("wb pc %h dst %0d we %b, expected pc %h dst %0d we %b",
                 got.pc, got.dst, got.regWrite, exp.pc, exp.dst, exp.regWrite));
        if (known && got.result !== exp.result)
            fail($sformatf("wb result %h at pc %h, expected %h", got.result, got.pc,
                 exp.result));
    endtask

    task automatic checkExc(input excCode got, input excCode exp, input logic [31:0] gotPc,
                            input logic [31:0] pcExp);
        if (got !== exp || gotPc !== pcExp)
            fail($sformatf("flush code %0d pc %h, expected code %0d pc %h",
                 got, gotPc, exp, pcExp));
        if (excVector !== (`EXC_BASE + `EXC_OFFSET))
            fail($sformatf("vector %h is wrong", excVector));
    endtask

    // a valid seen without its ready must stay up with the same payload
    task automatic checkBus(input axiReq now, input axiReq prev, input axiRsp rsp);
        if (prev.awvalid && !rsp.awready && (!now.awvalid || now.awaddr !== prev.awaddr))
            fail("AW valid or address changed before handshake");
        if (prev.wvalid && !rsp.wready &&
            (!now.wvalid || now.wdata !== prev.wdata || now.wstrb !== prev.wstrb))
            fail("W valid or data changed before handshake");
        if (prev.arvalid && !rsp.arready && (!now.arvalid || now.araddr !== prev.araddr))
            fail("AR valid or address changed before handshake");
    endtask

    always @(posedge clk) begin
        if (arstN) begin
            cycle++;
            checkBus(axiOut, prevReq, prevRsp);
            if (rspOwed && (axiOut.awvalid || axiOut.arvalid))
                fail("new access started before the previous response was taken");
            if (flushQ && (axiOut.awvalid || axiOut.wvalid || axiOut.arvalid))
                fail("bus access started for a flushed op");
            if (wbOut.valid) begin
                if (expWb.size() == 0) abortRun("writeback item appeared with none expected");
                checkWb(wbOut, expWb.pop_front(), expKnown.pop_front());
                wbTimes.push_back(cycle);
            end
            if (excFlush) begin
                if (expCode.size() == 0) abortRun("flush raised with none expected");
                checkExc(excCodeOut, expCode.pop_front(), excPc, expPc.pop_front());
            end
            flushQ = excFlush;
        end
        prevReq = axiOut;
        prevRsp = axiIn;
        awHsQ = axiOut.awvalid && axiIn.awready;
        wHsQ  = axiOut.wvalid && axiIn.wready;
        arHsQ = axiOut.arvalid && axiIn.arready;
        bHsQ  = axiIn.bvalid && axiOut.bready;
        rHsQ  = axiIn.rvalid && axiOut.rready;
        if (awHsQ) awAddrQ = axiOut.awaddr;
        if (wHsQ) begin
            wDataQ = axiOut.wdata;
            wStrbQ = axiOut.wstrb;
        end
        if (arHsQ) arAddrQ = axiOut.araddr;
        if (awHsQ || arHsQ) rspOwed = 1'b1;
        if (bHsQ || rHsQ) rspOwed = 1'b0;
    end

    // slave model with SLVERR at address bit 12 and a held-back response at bit 13
    always @(negedge clk) begin
        if (!arstN) begin
            axiIn = '0;
            {awGot, wGot, arGot, bPend} = '0;
        end else begin
            if (awHsQ) begin
                axiIn.awready = 1'b0;
                awGot = 1'b1;
            end else if (axiOut.awvalid && !awGot && !axiIn.awready) begin
                if (awDly == 0) axiIn.awready = 1'b1;
                else awDly--;
                if (axiIn.awready) awDly = $urandom % 4;
            end
            if (wHsQ) begin
                axiIn.wready = 1'b0;
                wGot = 1'b1;
            end else if (axiOut.wvalid && !wGot && !axiIn.wready) begin
                if (wDly == 0) axiIn.wready = 1'b1;
                else wDly--;
                if (axiIn.wready) wDly = $urandom % 4;
            end
            if (bHsQ) begin
                axiIn.bvalid = 1'b0;
                {bPend, awGot, wGot} = '0;
            end else if (awGot && wGot && !bPend) begin
                bPend = 1'b1;
                if (!awAddrQ[12])
                    for (int j = 0; j < 4; j++)
                        if (wStrbQ[j]) mem[awAddrQ[7:2]][8*j +: 8] = wDataQ[8*j +: 8];
                bDly = awAddrQ[13] ? `BUS_TIMEOUT + 8 : $urandom % 4;
            end else if (bPend && !axiIn.bvalid) begin
                if (bDly == 0) begin
                    axiIn.bvalid = 1'b1;
                    axiIn.bresp  = awAddrQ[12] ? 2'b10 : 2'b00;
                end else bDly--;
            end
            if (arHsQ) begin
                axiIn.arready = 1'b0;
                arGot = 1'b1;
                rDly  = arAddrQ[13] ? `BUS_TIMEOUT + 8 : $urandom % 4;
            end else if (axiOut.arvalid && !arGot && !axiIn.arready) begin
                if (arDly == 0) axiIn.arready = 1'b1;
                else arDly--;
                if (axiIn.arready) arDly = $urandom % 4;
            end
            if (rHsQ) begin
                axiIn.rvalid = 1'b0;
                arGot = 1'b0;
            end else if (arGot && !axiIn.rvalid) begin
                if (rDly == 0) begin
                    axiIn.rvalid = 1'b1;
                    axiIn.rdata  = mem[arAddrQ[7:2]];
                    axiIn.rresp  = arAddrQ[12] ? 2'b10 : 2'b00;
                end else rDly--;
            end
        end
    end

    // called on a falling edge, returns with a bubble on exeIn
    task automatic issue(input exeMemBundle e);
        memWbBundle w;
        excCode     x;
        bit         known;
        int         waited;
        int         k;
        waited = 0;
        exeIn  = e;
        while (memStall) begin
            @(negedge clk);
            waited++;
            if (waited > 200) abortRun("memStall never dropped for a new op");
        end
        refModel(e, mem, w, x, known);
        expWb.push_back(w);
        expKnown.push_back(known);
        if (x != excNone) begin
            expCode.push_back(x);
            expPc.push_back(e.pc);
        end
        @(negedge clk);
        exeIn = '0;
        if (x != excNone) begin
            k = 0;
            while (!excFlush) begin
                @(negedge clk);
                k++;
                if (k > 200) abortRun("expected flush never came");
            end
            @(negedge clk); // flush clears memReg, EXE side as well
        end
    endtask

    task automatic waitIdle();
        int k;
        k = 0;
        while (expWb.size() != 0 || expCode.size() != 0) begin
            @(negedge clk);
            k++;
            if (k > 300) abortRun("expected results never arrived");
        end
    endtask

    initial begin
        int          i;
        int          sel;
        int          seed;
        logic [31:0] a;
        accessKind   sk;
        accessKind   lk;
        seed = 38;
        void'($urandom(seed));
        arstN   = 1'b0;
        exeIn   = '0;
        axiIn   = '0;
        cycle   = 0;
        pcCount = 32'h0040_0000;
        {awDly, wDly, arDly, bDly, rDly} = '0;
        for (i = 0; i < 64; i++) mem[i] = 32'h9E37_79B9 * (i + 1);
        repeat (8) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        if (memStall || excFlush || wbOut.valid || axiOut.awvalid || axiOut.wvalid ||
            axiOut.arvalid || axiOut.bready || axiOut.rready)
            abortRun("outputs not low after reset");

        // stores then loads of the same address
        for (i = 0; i < 24; i++) begin
            sel = $urandom % 3;
            sk  = (sel == 0) ? kindSb : (sel == 1) ? kindSh : kindSw;
            lk  = (sel == 0) ? kindLb : (sel == 1) ? kindLh : kindLw;
            a   = 32'(($urandom % 64) * 4);
            if (sel == 0) a = a + 32'($urandom % 4);
            if (sel == 1) a = a + 32'(($urandom % 2) * 2);
            issue(mkOp(sk, a, $urandom, 1'b0, excNone));
            issue(mkOp(lk, a, 32'h0, 1'($urandom % 2), excNone));
        end
        waitIdle();

        wbTimes.delete();
        for (i = 0; i < 6; i++) issue(mkOp(kindNone, $urandom, 32'h0, 1'b0, excNone));
        waitIdle();
        for (i = 1; i < wbTimes.size(); i++)
            if (wbTimes[i] != wbTimes[i-1] + 1) fail("non-memory ops not back to back");

        issue(mkOp(kindLh, 32'h11, 32'h0, 1'b1, excNone));
        issue(mkOp(kindLw, 32'h22, 32'h0, 1'b0, excNone));
        issue(mkOp(kindSh, 32'h33, 32'h1234, 1'b0, excNone));
        issue(mkOp(kindSw, 32'h41, 32'h5678, 1'b0, excNone));
        issue(mkOp(kindLw, 32'h13, 32'h0, 1'b0, excOv)); // incoming cause wins
        waitIdle();

        // the load behind each timeout must not reach the bus before the late response
        issue(mkOp(kindLw, 32'h1004, 32'h0, 1'b0, excNone));
        issue(mkOp(kindSw, 32'h1008, $urandom, 1'b0, excNone));
        issue(mkOp(kindSw, 32'h2010, $urandom, 1'b0, excNone));
        issue(mkOp(kindLw, 32'h10, 32'h0, 1'b0, excNone));
        issue(mkOp(kindLw, 32'h2020, 32'h0, 1'b0, excNone));
        issue(mkOp(kindLh, 32'h26, 32'h0, 1'b1, excNone));
        waitIdle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/memStagePkg.sv
logic/pipeReg.sv
logic/dataAlign.sv
logic/excPriority.sv
logic/accessTimer.sv
logic/busMaster.sv
logic/memStage.sv
dv/memStageTb.sv

//--- run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
verilator --binary --timing -f project.f --top-module memStageTb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/VmemStageTb > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation incomplete"; exit 1; }
